//--- design/apb_subsystem_pkg.sv
// ========================================
// Shared widths, bus encodings, bridge states and GPIO register map
// Referenced by scoped name from the bridge and the GPIO blocks
// ========================================
package apb_subsystem_pkg;

  localparam int ADDR_WIDTH = 32;  // AHB and APB address
  localparam int DATA_WIDTH = 32;  // AHB and APB data

  // GPIO window, anything else is unmapped
  localparam logic [ADDR_WIDTH-1:0] GPIO_BASE = 32'h0000_0000;
  localparam logic [ADDR_WIDTH-1:0] GPIO_SPAN = 32'h0000_1000;  // 4 KB

  // AHB transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // AHB-Lite response, RETRY/SPLIT not used
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  typedef enum logic [2:0] {
    ST_IDLE, ST_WDATA, ST_SETUP, ST_ACCESS, ST_ERR1, ST_ERR2
  } bridge_state_e;

  // GPIO word offsets
  typedef enum logic [7:0] {
    REG_DATA_OUT = 8'h00,
    REG_DIR      = 8'h04,  // 1 = output
    REG_DATA_IN  = 8'h08,  // Read only
    REG_INT_EN   = 8'h0C,
    REG_INT_STAT = 8'h10   // Write one to clear
  } gpio_reg_e;

endpackage

//--- design/ahb2apb_bridge.sv
`timescale 1ns/1ns
// ========================================
// AHB-Lite slave bridging single transfers onto APB
// One setup plus one access cycle per transfer, two-cycle ERROR when unmapped
// ========================================
module ahb2apb_bridge (
  input  logic                                    i_hclk,
  input  logic                                    i_hresetn,
  // AHB slave side
  input  logic                                    i_hsel,
  input  logic [apb_subsystem_pkg::ADDR_WIDTH-1:0] i_haddr,
  input  logic [1:0]                              i_htrans,
  input  logic                                    i_hwrite,
  input  logic [apb_subsystem_pkg::DATA_WIDTH-1:0] i_hwdata,
  input  logic                                    i_hready_in,
  output logic [apb_subsystem_pkg::DATA_WIDTH-1:0] o_hrdata,
  output logic                                    o_hready,
  output logic                                    o_hresp,
  // APB master side
  output logic [apb_subsystem_pkg::ADDR_WIDTH-1:0] o_paddr,
  output logic                                    o_psel,
  output logic                                    o_penable,
  output logic                                    o_pwrite,
  output logic [apb_subsystem_pkg::DATA_WIDTH-1:0] o_pwdata,
  input  logic [apb_subsystem_pkg::DATA_WIDTH-1:0] i_prdata
);

  apb_subsystem_pkg::bridge_state_e state_q, state_d;

  logic [apb_subsystem_pkg::ADDR_WIDTH-1:0] addr_q;   // Latched address phase
  logic [apb_subsystem_pkg::DATA_WIDTH-1:0] wdata_q;  // Captured write data
  logic                                     write_q;
  logic                                     xfer_req;
  logic                                     accept;
  logic                                     mapped;

  // ========================================
  // Address phase decode
  // ========================================
  // SEQ handled like NONSEQ
  assign xfer_req = i_hsel && i_hready_in &&
                    (i_htrans == apb_subsystem_pkg::NONSEQ ||
                     i_htrans == apb_subsystem_pkg::SEQ);
  assign accept   = xfer_req && o_hready;  // Only when previous data phase ends

  // Offset compare, wraps cleanly below base
  assign mapped = (i_haddr - apb_subsystem_pkg::GPIO_BASE) < apb_subsystem_pkg::GPIO_SPAN;

  // ========================================
  // FSM
  // ========================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      apb_subsystem_pkg::ST_WDATA:  state_d = apb_subsystem_pkg::ST_SETUP;
      apb_subsystem_pkg::ST_SETUP:  state_d = apb_subsystem_pkg::ST_ACCESS;
      apb_subsystem_pkg::ST_ERR1:   state_d = apb_subsystem_pkg::ST_ERR2;
      default: begin  // IDLE, ACCESS, ERR2 can take a new transfer
        if (!accept) begin
          state_d = apb_subsystem_pkg::ST_IDLE;
        end else if (!mapped) begin
          state_d = apb_subsystem_pkg::ST_ERR1;
        end else if (i_hwrite) begin
          state_d = apb_subsystem_pkg::ST_WDATA;  // Wait for hwdata
        end else begin
          state_d = apb_subsystem_pkg::ST_SETUP;
        end
      end
    endcase
  end

  always_ff @(posedge i_hclk) begin
    if (!i_hresetn) begin
      state_q <= apb_subsystem_pkg::ST_IDLE;
      write_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        write_q <= i_hwrite;
      end
    end
  end

  always_ff @(posedge i_hclk) begin
    if (accept) begin
      addr_q <= i_haddr;
    end
    if (state_q == apb_subsystem_pkg::ST_WDATA) begin
      wdata_q <= i_hwdata;  // First data-phase cycle
    end
  end

  // ========================================
  // Bus outputs
  // ========================================
  assign o_hready  = (state_q == apb_subsystem_pkg::ST_IDLE)   ||
                     (state_q == apb_subsystem_pkg::ST_ACCESS) ||
                     (state_q == apb_subsystem_pkg::ST_ERR2);
  assign o_hresp   = ((state_q == apb_subsystem_pkg::ST_ERR1) ||
                      (state_q == apb_subsystem_pkg::ST_ERR2)) ?
                     apb_subsystem_pkg::ERROR : apb_subsystem_pkg::OKAY;
  assign o_psel    = (state_q == apb_subsystem_pkg::ST_SETUP) ||
                     (state_q == apb_subsystem_pkg::ST_ACCESS);
  assign o_penable = (state_q == apb_subsystem_pkg::ST_ACCESS);
  assign o_paddr   = addr_q;
  assign o_pwrite  = write_q;
  assign o_pwdata  = wdata_q;
  // Read data straight through on the access cycle
  assign o_hrdata  = (o_penable && !write_q) ? i_prdata : '0;

  // Access phase always preceded by a setup cycle
  a_access_after_setup: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    o_penable |-> $past(o_psel && !o_penable))
    else $error("APB access without setup");

  // Two-cycle ERROR response
  a_error_two_cycle: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    (o_hresp == apb_subsystem_pkg::ERROR && !o_hready) |=>
    (o_hresp == apb_subsystem_pkg::ERROR && o_hready))
    else $error("ERROR response not completed");

endmodule

//--- design/gpio_regs.sv
`timescale 1ns/1ns
// ========================================
// APB register file of the GPIO block
// Output, direction, interrupt enable and W1C interrupt status
// ========================================
module gpio_regs #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                                    i_pclk,
  input  logic                                    i_presetn,
  input  logic [apb_subsystem_pkg::ADDR_WIDTH-1:0] i_paddr,
  input  logic                                    i_psel,
  input  logic                                    i_penable,
  input  logic                                    i_pwrite,
  input  logic [apb_subsystem_pkg::DATA_WIDTH-1:0] i_pwdata,
  output logic [apb_subsystem_pkg::DATA_WIDTH-1:0] o_prdata,
  output logic [GPIO_WIDTH-1:0]                   o_data_out,
  output logic [GPIO_WIDTH-1:0]                   o_dir,
  input  logic [GPIO_WIDTH-1:0]                   i_data_in,   // Synchronized pins
  input  logic [GPIO_WIDTH-1:0]                   i_rise,      // Per-pin edge pulse
  output logic                                    o_gpio_irq
);

  // Top bit of the in-window offset
  localparam int OFF_MSB = $clog2(apb_subsystem_pkg::GPIO_SPAN) - 1;

  logic [GPIO_WIDTH-1:0] data_out_q;
  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] int_en_q;
  logic [GPIO_WIDTH-1:0] int_stat_q;
  logic [GPIO_WIDTH-1:0] wdata;
  logic [GPIO_WIDTH-1:0] stat_clr;
  logic [7:0]            reg_off;
  logic                  reg_hit;
  logic                  wr_en;

  assign reg_off  = i_paddr[7:0];
  assign reg_hit  = (i_paddr[OFF_MSB:8] == '0);  // No aliasing above 0xFF
  assign wr_en    = i_psel && i_penable && i_pwrite && reg_hit;  // Access cycle
  assign wdata    = i_pwdata[GPIO_WIDTH-1:0];
  assign stat_clr = (wr_en && reg_off == apb_subsystem_pkg::REG_INT_STAT) ? wdata : '0;

  always_ff @(posedge i_pclk) begin
    if (!i_presetn) begin
      data_out_q <= '0;
      dir_q      <= '0;
      int_en_q   <= '0;
      int_stat_q <= '0;
    end else begin
      if (wr_en) begin
        case (reg_off)
          apb_subsystem_pkg::REG_DATA_OUT: data_out_q <= wdata;
          apb_subsystem_pkg::REG_DIR:      dir_q      <= wdata;
          apb_subsystem_pkg::REG_INT_EN:   int_en_q   <= wdata;
          default: ;  // DATA_IN read only and INT_STAT below
        endcase
      end
      // Set beats clear in the same cycle
      int_stat_q <= (int_stat_q & ~stat_clr) | (i_rise & int_en_q);
    end
  end

  // Read mux with unused offsets at zero
  always_comb begin
    o_prdata = '0;
    if (reg_hit) begin
      case (reg_off)
        apb_subsystem_pkg::REG_DATA_OUT: o_prdata[GPIO_WIDTH-1:0] = data_out_q;
        apb_subsystem_pkg::REG_DIR:      o_prdata[GPIO_WIDTH-1:0] = dir_q;
        apb_subsystem_pkg::REG_DATA_IN:  o_prdata[GPIO_WIDTH-1:0] = i_data_in;
        apb_subsystem_pkg::REG_INT_EN:   o_prdata[GPIO_WIDTH-1:0] = int_en_q;
        apb_subsystem_pkg::REG_INT_STAT: o_prdata[GPIO_WIDTH-1:0] = int_stat_q;
        default: ;
      endcase
    end
  end

  assign o_data_out = data_out_q;
  assign o_dir      = dir_q;
  assign o_gpio_irq = |int_stat_q;  // Any pending status

  // Write to the input register leaves every register alone and clears no status
  a_data_in_read_only: assert property (@(posedge i_pclk) disable iff (!i_presetn)
    (wr_en && reg_off == apb_subsystem_pkg::REG_DATA_IN) |=>
    ($stable(data_out_q) && $stable(dir_q) && $stable(int_en_q) &&
     (($past(int_stat_q) & ~int_stat_q) == '0)))
    else $error("Write to DATA_IN changed register state");

endmodule

//--- design/gpio_core.sv
`timescale 1ns/1ns
// ========================================
// GPIO pin logic, two-flop input sync and rising-edge detect
// Drives pins and active-low output enables from the register file
// ========================================
module gpio_core #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  i_clk,
  input  logic                  i_resetn,
  input  logic [GPIO_WIDTH-1:0] i_gpio_pin_in,    // Asynchronous pins
  input  logic [GPIO_WIDTH-1:0] i_data_out,
  input  logic [GPIO_WIDTH-1:0] i_dir,            // 1 = output
  output logic [GPIO_WIDTH-1:0] o_gpio_pin_out,
  output logic [GPIO_WIDTH-1:0] o_n_gpio_pin_oe,  // Active low
  output logic [GPIO_WIDTH-1:0] o_data_in,
  output logic [GPIO_WIDTH-1:0] o_rise
);

  logic [GPIO_WIDTH-1:0] sync1_q;  // Metastability stage
  logic [GPIO_WIDTH-1:0] sync2_q;  // Stable sample
  logic [GPIO_WIDTH-1:0] prev_q;   // Previous sample for edge detect

  // ========================================
  // Input path
  // ========================================
  always_ff @(posedge i_clk) begin
    if (!i_resetn) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= i_gpio_pin_in;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign o_data_in = sync2_q;
  assign o_rise    = sync2_q & ~prev_q;  // One-cycle pulse per 0->1

  // Output path
  assign o_gpio_pin_out  = i_data_out;
  assign o_n_gpio_pin_oe = ~i_dir;  // Inputs after reset

endmodule

//--- design/apb_subsystem.sv
`timescale 1ns/1ns
// ========================================
// Peripheral subsystem top, AHB-to-APB bridge feeding one GPIO block
// ========================================
module apb_subsystem #(
  parameter int GPIO_WIDTH = 16  // 1 to 32 pins
) (
  input  logic                                    tb_hclk22,
  input  logic                                    hresetn22,
  // AHB-Lite slave port
  input  logic                                    i_hsel,
  input  logic [apb_subsystem_pkg::ADDR_WIDTH-1:0] i_haddr,
  input  logic [1:0]                              i_htrans,
  input  logic                                    i_hwrite,
  input  logic [apb_subsystem_pkg::DATA_WIDTH-1:0] i_hwdata,
  input  logic                                    i_hready_in,
  output logic [apb_subsystem_pkg::DATA_WIDTH-1:0] o_hrdata,
  output logic                                    o_hready,
  output logic                                    o_hresp,
  // GPIO pins
  input  logic [GPIO_WIDTH-1:0]                   i_gpio_pin_in,
  output logic [GPIO_WIDTH-1:0]                   o_gpio_pin_out,
  output logic [GPIO_WIDTH-1:0]                   o_n_gpio_pin_oe,
  output logic                                    o_gpio_irq
);

  // ========================================
  // Internal APB and GPIO nets
  // ========================================
  logic [apb_subsystem_pkg::ADDR_WIDTH-1:0] paddr;
  logic                                     psel;
  logic                                     penable;
  logic                                     pwrite;
  logic [apb_subsystem_pkg::DATA_WIDTH-1:0] pwdata;
  logic [apb_subsystem_pkg::DATA_WIDTH-1:0] prdata;
  logic [GPIO_WIDTH-1:0]                    data_out;
  logic [GPIO_WIDTH-1:0]                    dir;
  logic [GPIO_WIDTH-1:0]                    data_in;  // Synchronized
  logic [GPIO_WIDTH-1:0]                    rise;

  ahb2apb_bridge i_ahb2apb (
    .i_hclk(tb_hclk22), .i_hresetn(hresetn22),
    .i_hsel(i_hsel), .i_haddr(i_haddr), .i_htrans(i_htrans),
    .i_hwrite(i_hwrite), .i_hwdata(i_hwdata), .i_hready_in(i_hready_in),
    .o_hrdata(o_hrdata), .o_hready(o_hready), .o_hresp(o_hresp),
    .o_paddr(paddr), .o_psel(psel), .o_penable(penable),
    .o_pwrite(pwrite), .o_pwdata(pwdata), .i_prdata(prdata)
  );

  gpio_regs #(.GPIO_WIDTH(GPIO_WIDTH)) i_gpio_regs (
    .i_pclk(tb_hclk22), .i_presetn(hresetn22),  // Same clock as AHB
    .i_paddr(paddr), .i_psel(psel), .i_penable(penable),
    .i_pwrite(pwrite), .i_pwdata(pwdata), .o_prdata(prdata),
    .o_data_out(data_out), .o_dir(dir), .i_data_in(data_in), .i_rise(rise),
    .o_gpio_irq(o_gpio_irq)
  );

  gpio_core #(.GPIO_WIDTH(GPIO_WIDTH)) i_gpio_core (
    .i_clk(tb_hclk22), .i_resetn(hresetn22),
    .i_gpio_pin_in(i_gpio_pin_in), .i_data_out(data_out), .i_dir(dir),
    .o_gpio_pin_out(o_gpio_pin_out), .o_n_gpio_pin_oe(o_n_gpio_pin_oe),
    .o_data_in(data_in), .o_rise(rise)
  );

endmodule

//--- tests/apb_subsystem_tb.sv
`timescale 1ns/1ns
// ========================================
// Testbench of the AHB-to-APB GPIO subsystem as AHB master and pin driver
// Immediate and concurrent assertions check bus timing, registers and pins
// ========================================
module apb_subsystem_tb;

  localparam int          GPIO_WIDTH = 16;
  localparam logic [31:0] MASK       = (GPIO_WIDTH == 32) ? 32'hFFFF_FFFF :
                                       ((32'h1 << GPIO_WIDTH) - 32'h1);
  localparam logic [31:0] WINDOW_END = 32'h0000_1000;  // GPIO window is 0x0 up to 4 KB
  localparam int          TIMEOUT    = 8;              // Cycles allowed per wait loop

  logic                  tb_hclk22;
  logic                  hresetn22;
  logic                  i_hsel;
  logic [31:0]           i_haddr;
  logic [1:0]            i_htrans;
  logic                  i_hwrite;
  logic [31:0]           i_hwdata;
  logic                  i_hready_in;
  logic [31:0]           o_hrdata;
  logic                  o_hready;
  logic                  o_hresp;
  logic [GPIO_WIDTH-1:0] i_gpio_pin_in;
  logic [GPIO_WIDTH-1:0] o_gpio_pin_out;
  logic [GPIO_WIDTH-1:0] o_n_gpio_pin_oe;
  logic                  o_gpio_irq;
  logic                  addr_accept;  // Address phase taken by the slave
  logic [31:0]           rnd_state;
  logic [31:0]           exp_out;      // Expected register contents
  logic [31:0]           exp_dir;
  logic [31:0]           exp_en;

  apb_subsystem #(.GPIO_WIDTH(GPIO_WIDTH)) DUT (
    .tb_hclk22(tb_hclk22), .hresetn22(hresetn22),
    .i_hsel(i_hsel), .i_haddr(i_haddr), .i_htrans(i_htrans), .i_hwrite(i_hwrite),
    .i_hwdata(i_hwdata), .i_hready_in(i_hready_in),
    .o_hrdata(o_hrdata), .o_hready(o_hready), .o_hresp(o_hresp),
    .i_gpio_pin_in(i_gpio_pin_in), .o_gpio_pin_out(o_gpio_pin_out),
    .o_n_gpio_pin_oe(o_n_gpio_pin_oe), .o_gpio_irq(o_gpio_irq)
  );

  initial begin
    tb_hclk22 = 1'b0;
    forever #10 tb_hclk22 = ~tb_hclk22;  // 20 ns period
  end

  // ========================================
  // Helpers
  // ========================================
  task automatic next_cycle();
    @(posedge tb_hclk22);
    #2;  // Drive point after the edge
  endtask

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic fail_now(input string what);
    $display("%s", what);
    abort_run();
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else begin
        $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        abort_run();
      end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_rand(output logic [31:0] v);
    rnd_state = xorshift32(rnd_state);
    v = rnd_state;
  endtask

  // ========================================
  // AHB master
  // ========================================
  // Presents an address and returns in the first data-phase cycle
  task automatic issue_addr(input logic wr, input logic [31:0] addr);
    int n;
    n = 0;
    i_hsel   = 1'b1;
    i_haddr  = addr;
    i_htrans = apb_subsystem_pkg::NONSEQ;
    i_hwrite = wr;
    while (!o_hready) begin  // Hold address while the slave is busy
      if (n >= TIMEOUT) fail_now("timeout waiting for the slave to take an address");
      else begin
        n++;
        next_cycle();
      end
    end
    next_cycle();
    i_hsel   = 1'b0;
    i_htrans = apb_subsystem_pkg::IDLE;
    i_hwrite = 1'b0;
  endtask

  // Runs to the last data-phase cycle and counts wait states
  task automatic finish_data(input logic [31:0] wdata, output int lows,
                             output logic [31:0] rdata, output logic resp);
    lows     = 0;
    i_hwdata = wdata;
    while (!o_hready) begin
      if (lows >= TIMEOUT) fail_now("timeout waiting for the end of a data phase");
      else begin
        lows++;
        next_cycle();
      end
    end
    rdata = o_hrdata;
    resp  = o_hresp;
  endtask

  // One transfer that ends in its last data-phase cycle so the next can overlap
  task automatic xfer(input string name, input logic wr, input logic [31:0] addr,
                      input logic [31:0] wdata, output logic [31:0] rdata);
    int   lows;
    int   exp_lows;
    logic resp;
    logic mapped;
    mapped = (addr < WINDOW_END);
    issue_addr(wr, addr);
    finish_data(wdata, lows, rdata, resp);
    exp_lows = (mapped && wr) ? 2 : 1;  // Write waits for hwdata capture
    check_eq({name, " hready low cycles"}, exp_lows, lows);
    check_eq({name, " hresp"}, {31'b0, !mapped}, {31'b0, resp});
  endtask

  task automatic bus_write(input string name, input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    xfer(name, 1'b1, addr, data, unused_rd);
    next_cycle();  // Register commits on this edge
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    xfer(name, 1'b0, addr, 32'h0, rd);
    next_cycle();
    check_eq(name, exp, rd);
  endtask

  // Transfer start as seen by any AHB-Lite slave
  assign addr_accept = i_hsel && i_hready_in && o_hready &&
                       (i_htrans == apb_subsystem_pkg::NONSEQ ||
                        i_htrans == apb_subsystem_pkg::SEQ);

  a_unmapped_error: assert property (@(posedge tb_hclk22) disable iff (!hresetn22)
    (addr_accept && i_haddr >= WINDOW_END) |=> (o_hresp && !o_hready))
    else fail_now("unmapped address did not start a two-cycle ERROR response");

  a_mapped_okay: assert property (@(posedge tb_hclk22) disable iff (!hresetn22)
    (addr_accept && i_haddr < WINDOW_END) |=> !o_hresp)
    else fail_now("mapped transfer was answered with ERROR");

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    logic [31:0] v;
    logic [31:0] d;
    logic [31:0] rd;
    int          n;
    rnd_state     = 32'hd9725f7d;
    hresetn22     = 1'b0;
    i_hsel        = 1'b0;
    i_haddr       = 32'h0;
    i_htrans      = apb_subsystem_pkg::IDLE;
    i_hwrite      = 1'b0;
    i_hwdata      = 32'h0;
    i_hready_in   = 1'b1;
    i_gpio_pin_in = '0;
    exp_out       = 32'h0;
    exp_dir       = 32'h0;
    exp_en        = 32'h0;
    repeat (16) @(posedge tb_hclk22);
    #2;
    hresetn22 = 1'b1;
    next_cycle();

    // Reset state where unused offset 0x14 reads zero
    check_eq("reset hready", 32'h1, {31'b0, o_hready});
    check_eq("reset hresp", 32'h0, {31'b0, o_hresp});
    check_eq("reset pin oe", MASK, 32'(o_n_gpio_pin_oe));
    check_eq("reset irq", 32'h0, {31'b0, o_gpio_irq});
    for (int a = 0; a <= 20; a += 4) begin
      read_expect("reset register", 32'(a), 32'h0);
    end

    // Output and direction registers drive the pins
    repeat (4) begin
      draw_rand(d);
      draw_rand(v);
      bus_write("write DATA_OUT", 32'h00, d);
      bus_write("write DIR", 32'h04, v);
      exp_out = d & MASK;
      exp_dir = v & MASK;
      read_expect("readback DATA_OUT", 32'h00, exp_out);
      read_expect("readback DIR", 32'h04, exp_dir);
      check_eq("pin out", exp_out, 32'(o_gpio_pin_out));
      check_eq("pin oe", ~exp_dir & MASK, 32'(o_n_gpio_pin_oe));
    end

    // Input sampling through the synchronizer
    repeat (3) begin
      draw_rand(v);
      i_gpio_pin_in = v[GPIO_WIDTH-1:0];
      repeat (3) next_cycle();
      read_expect("sampled DATA_IN", 32'h08, v & MASK);
    end
    read_expect("status with interrupts off", 32'h10, 32'h0);

    // Interrupts with pin 0 enabled and pin 1 disabled
    i_gpio_pin_in = '0;
    repeat (3) next_cycle();
    draw_rand(v);
    exp_en = (v | 32'h1) & ~32'h2 & MASK;
    bus_write("write INT_EN", 32'h0C, exp_en);
    i_gpio_pin_in = '1;  // Every pin rises
    n = 0;
    while (!o_gpio_irq) begin
      if (n >= TIMEOUT) fail_now("timeout waiting for o_gpio_irq to rise");
      else begin
        n++;
        next_cycle();
      end
    end
    read_expect("status after rise", 32'h10, exp_en);
    draw_rand(v);
    bus_write("partial clear", 32'h10, v);
    read_expect("status after partial clear", 32'h10, exp_en & ~v);
    check_eq("irq after partial clear", {31'b0, |(exp_en & ~v)}, {31'b0, o_gpio_irq});
    bus_write("full clear", 32'h10, 32'hFFFF_FFFF);
    read_expect("status after full clear", 32'h10, 32'h0);
    check_eq("irq after full clear", 32'h0, {31'b0, o_gpio_irq});

    // Unmapped addresses that would alias DATA_OUT and INT_EN if they reached APB
    draw_rand(v);
    bus_write("unmapped write", WINDOW_END, v);
    bus_write("unmapped write high", 32'h8000_000C, ~v);
    xfer("unmapped read", 1'b0, 32'hFFFF_FFF0, 32'h0, rd);
    next_cycle();

    // Nothing starts while hready_in is low
    i_hsel      = 1'b1;
    i_haddr     = 32'h00;
    i_htrans    = apb_subsystem_pkg::NONSEQ;
    i_hwrite    = 1'b1;
    i_hwdata    = ~exp_out;
    i_hready_in = 1'b0;
    repeat (3) begin
      next_cycle();
      check_eq("hready with hready_in low", 32'h1, {31'b0, o_hready});
    end
    i_hsel      = 1'b0;
    i_htrans    = apb_subsystem_pkg::IDLE;
    i_hwrite    = 1'b0;
    i_hready_in = 1'b1;
    read_expect("DATA_OUT kept", 32'h00, exp_out);
    read_expect("DIR kept", 32'h04, exp_dir);
    read_expect("INT_EN kept", 32'h0C, exp_en);

    // Read issued in the last data-phase cycle of a write
    draw_rand(d);
    xfer("back-to-back write", 1'b1, 32'h00, d, rd);
    xfer("back-to-back read", 1'b0, 32'h00, 32'h0, rd);
    next_cycle();
    exp_out = d & MASK;
    check_eq("back-to-back read data", exp_out, rd);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- apb_subsystem.f
design/apb_subsystem_pkg.sv
design/ahb2apb_bridge.sv
design/gpio_regs.sv
design/gpio_core.sv
design/apb_subsystem.sv
tests/apb_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the subsystem testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module apb_subsystem_tb -f apb_subsystem.f &&
  ./obj_dir/Vapb_subsystem_tb | tee /dev/stderr | grep -qx 'STATUS: PASS' ||
  { echo "simulation failed"; exit 1; }
echo "simulation passed"
